/* isa_defs_pkg.sv */
package isa_defs_pkg;

    // Major opcodes of the 3R format, taken from instr[31:15]
    typedef enum logic [16:0] {
        OPC_ADD_W   = 17'h00020,
        OPC_SUB_W   = 17'h00022,
        OPC_SLT     = 17'h00024,
        OPC_SLTU    = 17'h00025,
        OPC_NOR     = 17'h00028,
        OPC_AND     = 17'h00029,
        OPC_OR      = 17'h0002a,
        OPC_XOR     = 17'h0002b,
        OPC_ORN     = 17'h0002c,
        OPC_ANDN    = 17'h0002d,
        OPC_SLL_W   = 17'h0002e,
        OPC_SRL_W   = 17'h0002f,
        OPC_SRA_W   = 17'h00030,
        OPC_MUL_W   = 17'h00038,
        OPC_MULH_W  = 17'h00039,
        OPC_MULH_WU = 17'h0003a,
        OPC_DIV_W   = 17'h00040,
        OPC_MOD_W   = 17'h00041,
        OPC_DIV_WU  = 17'h00042,
        OPC_MOD_WU  = 17'h00043,
        OPC_BREAK   = 17'h00054,
        OPC_SYSCALL = 17'h00056,
        OPC_INVTLB  = 17'h00c93,
        OPC_IDLE    = 17'h07091,
        OPC_DBAR    = 17'h070e4,
        OPC_IBAR    = 17'h070e5
    } opcode_3r_e;

    typedef enum logic [7:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_NOR, ALU_AND, ALU_OR, ALU_XOR, ALU_ORN, ALU_ANDN,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_MUL, ALU_MULH, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_MOD, ALU_MODU
    } alu_op_e;

    // Result class picks which ALU unit drives the result
    typedef enum logic [2:0] {
        SEL_NOP,
        SEL_ARITH,
        SEL_LOGIC,
        SEL_SHIFT
    } alu_sel_e;

    typedef enum logic [2:0] {
        TRAP_NONE,
        TRAP_BRK,
        TRAP_SYS,
        TRAP_IDLE,
        TRAP_INVTLB
    } trap_e;

    // Syscall code reserved as a simulation stop marker
    localparam logic [14:0] SYSCALL_STOP_CODE = 15'h11;

endpackage

/* core_types_pkg.sv */
package core_types_pkg;

    // Datapath width of registers and ALU operands
    localparam int DATA_WIDTH = 32;

    // General register file geometry
    localparam int GPR_NUM    = 32;
    localparam int GPR_ADDR_W = $clog2(GPR_NUM);

endpackage

/* decoder_3r.sv */
`timescale 1ns/1ps

// Instruction layout {opcode[16:0], rk[4:0], rj[4:0], rd[4:0]}
module decoder_3r (
    input  logic [31:0]                           instr_i,
    output logic                                  decode_valid_o,
    // Read valids as {rk, rj}
    output logic [1:0]                            reg_read_valid_o,
    output logic [core_types_pkg::GPR_ADDR_W-1:0] rj_addr_o,
    output logic [core_types_pkg::GPR_ADDR_W-1:0] rk_addr_o,
    output logic                                  reg_write_valid_o,
    output logic [core_types_pkg::GPR_ADDR_W-1:0] rd_addr_o,
    output isa_defs_pkg::alu_op_e                 alu_op_o,
    output isa_defs_pkg::alu_sel_e                alu_sel_o,
    output isa_defs_pkg::trap_e                   trap_o,
    output logic [4:0]                            invtlb_op_o
);
    import isa_defs_pkg::*;
    import core_types_pkg::*;

    logic [GPR_ADDR_W-1:0] rd;
    logic [GPR_ADDR_W-1:0] rj;
    logic [GPR_ADDR_W-1:0] rk;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];
    assign rk = instr_i[14:10];

    always_comb begin
        // Plain three-register operation unless the opcode says otherwise
        decode_valid_o    = 1'b1;
        reg_read_valid_o  = 2'b11;
        rj_addr_o         = rj;
        rk_addr_o         = rk;
        reg_write_valid_o = 1'b1;
        rd_addr_o         = rd;
        alu_op_o          = ALU_NOP;
        alu_sel_o         = SEL_NOP;
        trap_o            = TRAP_NONE;
        invtlb_op_o       = '0;

        case (instr_i[31:15])
            OPC_ADD_W:   begin alu_op_o = ALU_ADD;   alu_sel_o = SEL_ARITH; end
            OPC_SUB_W:   begin alu_op_o = ALU_SUB;   alu_sel_o = SEL_ARITH; end
            OPC_SLT:     begin alu_op_o = ALU_SLT;   alu_sel_o = SEL_ARITH; end
            OPC_SLTU:    begin alu_op_o = ALU_SLTU;  alu_sel_o = SEL_ARITH; end
            OPC_MUL_W:   begin alu_op_o = ALU_MUL;   alu_sel_o = SEL_ARITH; end
            OPC_MULH_W:  begin alu_op_o = ALU_MULH;  alu_sel_o = SEL_ARITH; end
            OPC_MULH_WU: begin alu_op_o = ALU_MULHU; alu_sel_o = SEL_ARITH; end
            OPC_DIV_W:   begin alu_op_o = ALU_DIV;   alu_sel_o = SEL_ARITH; end
            OPC_DIV_WU:  begin alu_op_o = ALU_DIVU;  alu_sel_o = SEL_ARITH; end
            OPC_MOD_W:   begin alu_op_o = ALU_MOD;   alu_sel_o = SEL_ARITH; end
            OPC_MOD_WU:  begin alu_op_o = ALU_MODU;  alu_sel_o = SEL_ARITH; end
            OPC_NOR:     begin alu_op_o = ALU_NOR;   alu_sel_o = SEL_LOGIC; end
            OPC_AND:     begin alu_op_o = ALU_AND;   alu_sel_o = SEL_LOGIC; end
            OPC_OR:      begin alu_op_o = ALU_OR;    alu_sel_o = SEL_LOGIC; end
            OPC_XOR:     begin alu_op_o = ALU_XOR;   alu_sel_o = SEL_LOGIC; end
            OPC_ORN:     begin alu_op_o = ALU_ORN;   alu_sel_o = SEL_LOGIC; end
            OPC_ANDN:    begin alu_op_o = ALU_ANDN;  alu_sel_o = SEL_LOGIC; end
            OPC_SLL_W:   begin alu_op_o = ALU_SLL;   alu_sel_o = SEL_SHIFT; end
            OPC_SRL_W:   begin alu_op_o = ALU_SRL;   alu_sel_o = SEL_SHIFT; end
            OPC_SRA_W:   begin alu_op_o = ALU_SRA;   alu_sel_o = SEL_SHIFT; end
            OPC_BREAK, OPC_SYSCALL, OPC_IDLE, OPC_DBAR, OPC_IBAR: begin
                // None of these touch the register file
                reg_read_valid_o  = 2'b00;
                rj_addr_o         = '0;
                rk_addr_o         = '0;
                reg_write_valid_o = 1'b0;
                rd_addr_o         = '0;
                if (instr_i[31:15] == OPC_BREAK) begin
                    trap_o = TRAP_BRK;
                end else if (instr_i[31:15] == OPC_IDLE) begin
                    trap_o = TRAP_IDLE;
                end else if (instr_i[31:15] == OPC_SYSCALL &&
                             instr_i[14:0] != SYSCALL_STOP_CODE) begin
                    trap_o = TRAP_SYS;
                end
            end
            OPC_INVTLB: begin
                // rd field is the invalidate op, not a register
                reg_write_valid_o = 1'b0;
                rd_addr_o         = '0;
                invtlb_op_o       = instr_i[4:0];
                trap_o            = TRAP_INVTLB;
            end
            default: begin
                decode_valid_o    = 1'b0;
                reg_read_valid_o  = 2'b00;
                rj_addr_o         = '0;
                rk_addr_o         = '0;
                reg_write_valid_o = 1'b0;
                rd_addr_o         = '0;
            end
        endcase
    end

endmodule

/* gpr_file.sv */
`timescale 1ns/1ps

module gpr_file (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic [core_types_pkg::GPR_ADDR_W-1:0] ra_i,
    input  logic [core_types_pkg::GPR_ADDR_W-1:0] rb_i,
    input  logic                                  we_i,
    input  logic [core_types_pkg::GPR_ADDR_W-1:0] waddr_i,
    input  logic [core_types_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic                                  load_en_i,
    input  logic [core_types_pkg::GPR_ADDR_W-1:0] load_addr_i,
    input  logic [core_types_pkg::DATA_WIDTH-1:0] load_data_i,
    output logic [core_types_pkg::DATA_WIDTH-1:0] ra_data_o,
    output logic [core_types_pkg::DATA_WIDTH-1:0] rb_data_o
);
    import core_types_pkg::*;

    logic [DATA_WIDTH-1:0] regs [GPR_NUM];

    // Core write-back wins over the host load port
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            if (waddr_i != '0) begin
                regs[waddr_i] <= wdata_i;
            end
        end else if (load_en_i && load_addr_i != '0) begin
            regs[load_addr_i] <= load_data_i;
        end
    end

    // r0 is hardwired to zero
    assign ra_data_o = (ra_i == '0) ? '0 : regs[ra_i];
    assign rb_data_o = (rb_i == '0) ? '0 : regs[rb_i];

endmodule

/* alu_3r.sv */
`timescale 1ns/1ps

module alu_3r (
    input  isa_defs_pkg::alu_op_e                 op_i,
    input  isa_defs_pkg::alu_sel_e                sel_i,
    input  logic [core_types_pkg::DATA_WIDTH-1:0] src1_i,
    input  logic [core_types_pkg::DATA_WIDTH-1:0] src2_i,
    output logic [core_types_pkg::DATA_WIDTH-1:0] result_o
);
    import isa_defs_pkg::*;
    import core_types_pkg::*;

    logic [DATA_WIDTH-1:0]            arith_res;
    logic [DATA_WIDTH-1:0]            logic_res;
    logic [DATA_WIDTH-1:0]            shift_res;
    logic signed [2*DATA_WIDTH-1:0]   prod_s;
    logic [2*DATA_WIDTH-1:0]          prod_u;
    logic [DATA_WIDTH-1:0]            quo_s;
    logic [DATA_WIDTH-1:0]            rem_s;
    logic [DATA_WIDTH-1:0]            quo_u;
    logic [DATA_WIDTH-1:0]            rem_u;
    logic                             div_zero;
    logic                             div_ovf;
    logic [4:0]                       shamt;

    assign prod_s = $signed(src1_i) * $signed(src2_i);
    assign prod_u = src1_i * src2_i;

    assign div_zero = (src2_i == '0);
    // Most negative value divided by -1
    assign div_ovf  = (src1_i == {1'b1, {(DATA_WIDTH-1){1'b0}}}) && (src2_i == '1);

    always_comb begin
        // Divide by zero keeps the dividend as remainder
        quo_s = '0;
        rem_s = src1_i;
        quo_u = '0;
        rem_u = src1_i;
        if (!div_zero) begin
            quo_u = src1_i / src2_i;
            rem_u = src1_i % src2_i;
            if (div_ovf) begin
                quo_s = src1_i;
                rem_s = '0;
            end else begin
                quo_s = $signed(src1_i) / $signed(src2_i);
                rem_s = $signed(src1_i) % $signed(src2_i);
            end
        end
    end

    always_comb begin
        case (op_i)
            ALU_ADD:   arith_res = src1_i + src2_i;
            ALU_SUB:   arith_res = src1_i - src2_i;
            ALU_SLT:   arith_res = {{(DATA_WIDTH-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
            ALU_SLTU:  arith_res = {{(DATA_WIDTH-1){1'b0}}, src1_i < src2_i};
            ALU_MUL:   arith_res = prod_u[DATA_WIDTH-1:0];
            ALU_MULH:  arith_res = prod_s[2*DATA_WIDTH-1:DATA_WIDTH];
            ALU_MULHU: arith_res = prod_u[2*DATA_WIDTH-1:DATA_WIDTH];
            ALU_DIV:   arith_res = quo_s;
            ALU_DIVU:  arith_res = quo_u;
            ALU_MOD:   arith_res = rem_s;
            ALU_MODU:  arith_res = rem_u;
            default:   arith_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            ALU_NOR:  logic_res = ~(src1_i | src2_i);
            ALU_AND:  logic_res = src1_i & src2_i;
            ALU_OR:   logic_res = src1_i | src2_i;
            ALU_XOR:  logic_res = src1_i ^ src2_i;
            ALU_ORN:  logic_res = src1_i | ~src2_i;
            ALU_ANDN: logic_res = src1_i & ~src2_i;
            default:  logic_res = '0;
        endcase
    end

    // Only the low five bits of rk count as shift amount
    assign shamt = src2_i[4:0];

    always_comb begin
        case (op_i)
            ALU_SLL: shift_res = src1_i << shamt;
            ALU_SRL: shift_res = src1_i >> shamt;
            ALU_SRA: shift_res = $signed(src1_i) >>> shamt;
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (sel_i)
            SEL_ARITH: result_o = arith_res;
            SEL_LOGIC: result_o = logic_res;
            SEL_SHIFT: result_o = shift_res;
            default:   result_o = '0;
        endcase
    end

endmodule

/* issue_ctrl.sv */
`timescale 1ns/1ps

module issue_ctrl (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  req_i,
    input  logic [31:0]                           instr_i,
    input  logic                                  decode_valid_i,
    input  logic                                  reg_write_valid_i,
    input  logic [core_types_pkg::GPR_ADDR_W-1:0] rd_addr_i,
    input  isa_defs_pkg::trap_e                   trap_i,
    input  logic [core_types_pkg::DATA_WIDTH-1:0] result_i,
    output logic                                  ack_o,
    output logic [31:0]                           instr_q_o,
    output logic                                  gpr_we_o,
    output logic                                  wb_valid_o,
    output logic [core_types_pkg::GPR_ADDR_W-1:0] wb_addr_o,
    output logic [core_types_pkg::DATA_WIDTH-1:0] wb_data_o,
    output isa_defs_pkg::trap_e                   trap_o,
    output logic                                  illegal_o
);
    import isa_defs_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_ACK,
        ST_WAIT_LOW
    } state_e;

    state_e state_q;
    logic   wb_en;

    // Traps and illegal opcodes never reach the register file
    assign wb_en    = decode_valid_i && reg_write_valid_i && (trap_i == TRAP_NONE);
    assign gpr_we_o = (state_q == ST_EXEC) && wb_en;
    assign ack_o    = (state_q == ST_WAIT_LOW);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:     if (req_i) state_q <= ST_EXEC;
                ST_EXEC:     state_q <= ST_ACK;
                ST_ACK:      state_q <= ST_WAIT_LOW;
                ST_WAIT_LOW: if (!req_i) state_q <= ST_IDLE;
                default:     state_q <= ST_IDLE;
            endcase
        end
    end

    // Instruction held for the whole transaction
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_i) begin
            instr_q_o <= instr_i;
        end
    end

    // Outcome captured together with the register write
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_addr_o  <= '0;
            wb_data_o  <= '0;
            trap_o     <= TRAP_NONE;
            illegal_o  <= 1'b0;
        end else if (state_q == ST_EXEC) begin
            wb_valid_o <= wb_en;
            wb_addr_o  <= wb_en ? rd_addr_i : '0;
            wb_data_o  <= wb_en ? result_i : '0;
            trap_o     <= trap_i;
            illegal_o  <= !decode_valid_i;
        end
    end

endmodule

/* exec3r_top.sv */
`timescale 1ns/1ps

module exec3r_top (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic                                  req_i,
    input  logic [31:0]                           instr_i,
    input  logic                                  load_en_i,
    input  logic [core_types_pkg::GPR_ADDR_W-1:0] load_addr_i,
    input  logic [core_types_pkg::DATA_WIDTH-1:0] load_data_i,
    output logic                                  ack_o,
    output logic                                  wb_valid_o,
    output logic [core_types_pkg::GPR_ADDR_W-1:0] wb_addr_o,
    output logic [core_types_pkg::DATA_WIDTH-1:0] wb_data_o,
    output isa_defs_pkg::trap_e                   trap_o,
    output logic                                  illegal_o
);
    import isa_defs_pkg::*;
    import core_types_pkg::*;

    logic [31:0]           instr_q;
    logic                  decode_valid;
    logic                  reg_write_valid;
    logic [GPR_ADDR_W-1:0] rj_addr;
    logic [GPR_ADDR_W-1:0] rk_addr;
    logic [GPR_ADDR_W-1:0] rd_addr;
    alu_op_e               alu_op;
    alu_sel_e              alu_sel;
    trap_e                 dec_trap;
    logic [DATA_WIDTH-1:0] rj_data;
    logic [DATA_WIDTH-1:0] rk_data;
    logic [DATA_WIDTH-1:0] alu_result;
    logic                  gpr_we;

    issue_ctrl u_issue_ctrl (
        .clk               (clk),
        .reset_i           (reset_i),
        .req_i             (req_i),
        .instr_i           (instr_i),
        .decode_valid_i    (decode_valid),
        .reg_write_valid_i (reg_write_valid),
        .rd_addr_i         (rd_addr),
        .trap_i            (dec_trap),
        .result_i          (alu_result),
        .ack_o             (ack_o),
        .instr_q_o         (instr_q),
        .gpr_we_o          (gpr_we),
        .wb_valid_o        (wb_valid_o),
        .wb_addr_o         (wb_addr_o),
        .wb_data_o         (wb_data_o),
        .trap_o            (trap_o),
        .illegal_o         (illegal_o)
    );

    // Read valids and the invtlb op have no consumer in this slice
    decoder_3r u_decoder_3r (
        .instr_i           (instr_q),
        .decode_valid_o    (decode_valid),
        .reg_read_valid_o  (),
        .rj_addr_o         (rj_addr),
        .rk_addr_o         (rk_addr),
        .reg_write_valid_o (reg_write_valid),
        .rd_addr_o         (rd_addr),
        .alu_op_o          (alu_op),
        .alu_sel_o         (alu_sel),
        .trap_o            (dec_trap),
        .invtlb_op_o       ()
    );

    gpr_file u_gpr_file (
        .clk         (clk),
        .reset_i     (reset_i),
        .ra_i        (rj_addr),
        .rb_i        (rk_addr),
        .we_i        (gpr_we),
        .waddr_i     (rd_addr),
        .wdata_i     (alu_result),
        .load_en_i   (load_en_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .ra_data_o   (rj_data),
        .rb_data_o   (rk_data)
    );

    alu_3r u_alu_3r (
        .op_i     (alu_op),
        .sel_i    (alu_sel),
        .src1_i   (rj_data),
        .src2_i   (rk_data),
        .result_o (alu_result)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);
    // 40 ns period
    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         req_i,
    input  logic         ack_i,
    input  logic         wb_valid_i,
    input  logic [4:0]   wb_addr_i,
    input  logic [31:0]  wb_data_i,
    input  logic [2:0]   trap_i,
    input  logic         illegal_i,
    input  logic [255:0] exp_name_i,
    input  logic         exp_wb_valid_i,
    input  logic [4:0]   exp_wb_addr_i,
    input  logic [31:0]  exp_wb_data_i,
    input  logic [2:0]   exp_trap_i,
    input  logic         exp_illegal_i,
    output int           err_cnt_o,
    output int           check_cnt_o
);
    // Sampling edge of req plus two more edges until ack
    localparam int ACK_EDGES = 3;

    int   err_cnt   = 0;
    int   check_cnt = 0;
    int   req_edges = 0;
    logic in_reset  = 1'b0;
    logic ack_seen  = 1'b0;

    assign err_cnt_o   = err_cnt;
    assign check_cnt_o = check_cnt;

    task automatic compare(input logic [255:0] name, input logic [127:0] field,
                           input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error %0s %0s: expected %h, actual %h", name, field, expected, actual);
            err_cnt++;
        end
    endtask

    // Edges seen with req high while ack is still low
    always @(posedge clk_i) begin
        in_reset <= reset_i;
        if (reset_i || !req_i) begin
            req_edges <= 0;
        end else if (!ack_i) begin
            req_edges <= req_edges + 1;
        end
    end

    always @(negedge clk_i) begin
        if (in_reset) begin
            // Outputs come out of reset idle
            compare("reset", "ack", 32'd0, {31'd0, ack_i});
            compare("reset", "wb_valid", 32'd0, {31'd0, wb_valid_i});
            compare("reset", "illegal", 32'd0, {31'd0, illegal_i});
            compare("reset", "trap", 32'd0, {29'd0, trap_i});
            ack_seen = 1'b0;
        end else begin
            if (ack_i && !ack_seen) begin
                check_cnt++;
                compare(exp_name_i, "ack latency", ACK_EDGES, req_edges);
                compare(exp_name_i, "wb_valid", {31'd0, exp_wb_valid_i}, {31'd0, wb_valid_i});
                compare(exp_name_i, "wb_addr", {27'd0, exp_wb_addr_i}, {27'd0, wb_addr_i});
                compare(exp_name_i, "wb_data", exp_wb_data_i, wb_data_i);
                compare(exp_name_i, "trap", {29'd0, exp_trap_i}, {29'd0, trap_i});
                compare(exp_name_i, "illegal", {31'd0, exp_illegal_i}, {31'd0, illegal_i});
            end
            ack_seen = ack_i;
        end
    end

endmodule

/* tb_top.sv */
`timescale 1ns/1ps

module tb_top;

    // Cycles allowed for each ack edge
    localparam int ACK_TIMEOUT = 20;

    logic                clk;
    logic                reset;
    logic                req;
    logic [31:0]         instr;
    logic                load_en;
    logic [4:0]          load_addr;
    logic [31:0]         load_data;
    logic                ack;
    logic                wb_valid;
    logic [4:0]          wb_addr;
    logic [31:0]         wb_data;
    isa_defs_pkg::trap_e trap;
    logic                illegal;

    logic [255:0] exp_name;
    logic         exp_wb_valid;
    logic [4:0]   exp_wb_addr;
    logic [31:0]  exp_wb_data;
    logic [2:0]   exp_trap;
    logic         exp_illegal;

    int   value_errs;
    int   checks_done;
    int   other_errs;
    int   tests_run;
    logic stalled;

    tb_clk_gen u_clk_gen (
        .clk_o (clk)
    );

    exec3r_top u_dut (
        .clk         (clk),
        .reset_i     (reset),
        .req_i       (req),
        .instr_i     (instr),
        .load_en_i   (load_en),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .ack_o       (ack),
        .wb_valid_o  (wb_valid),
        .wb_addr_o   (wb_addr),
        .wb_data_o   (wb_data),
        .trap_o      (trap),
        .illegal_o   (illegal)
    );

    tb_checker u_checker (
        .clk_i          (clk),
        .reset_i        (reset),
        .req_i          (req),
        .ack_i          (ack),
        .wb_valid_i     (wb_valid),
        .wb_addr_i      (wb_addr),
        .wb_data_i      (wb_data),
        .trap_i         (trap),
        .illegal_i      (illegal),
        .exp_name_i     (exp_name),
        .exp_wb_valid_i (exp_wb_valid),
        .exp_wb_addr_i  (exp_wb_addr),
        .exp_wb_data_i  (exp_wb_data),
        .exp_trap_i     (exp_trap),
        .exp_illegal_i  (exp_illegal),
        .err_cnt_o      (value_errs),
        .check_cnt_o    (checks_done)
    );

    // Expected result of the opcodes that random lines may use
    function automatic logic [31:0] expected_alu(input logic [16:0] opc,
                                                 input logic [31:0] a, input logic [31:0] b);
        case (opc)
            17'h00020: return a + b;
            17'h00022: return a - b;
            17'h00024: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            17'h00025: return (a < b) ? 32'd1 : 32'd0;
            17'h00029: return a & b;
            17'h0002a: return a | b;
            17'h0002b: return a ^ b;
            default:   return 32'd0;
        endcase
    endfunction

    task automatic preload_reg(input logic [4:0] addr, input logic [31:0] data);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        load_en   = 1'b0;
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ACK_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (ack !== level) begin
            $display("timeout: ack did not %0s within %0d cycles in test %0s",
                     level ? "rise" : "fall", ACK_TIMEOUT, exp_name);
            other_errs++;
            stalled = 1'b1;
        end
    endtask

    initial begin
        string        line;
        int           fd;
        int           n;
        int           rnd;
        logic [255:0] name;
        logic [4:0]   pa1;
        logic [4:0]   pa2;
        logic [31:0]  pd1;
        logic [31:0]  pd2;
        logic [31:0]  ins;
        logic         wv;
        logic [4:0]   wa;
        logic [31:0]  wd;
        logic [2:0]   tr;
        logic         il;

        reset        = 1'b1;
        req          = 1'b0;
        instr        = '0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        exp_name     = '0;
        exp_wb_valid = 1'b0;
        exp_wb_addr  = '0;
        exp_wb_data  = '0;
        exp_trap     = '0;
        exp_illegal  = 1'b0;
        other_errs   = 0;
        tests_run    = 0;
        stalled      = 1'b0;
        void'($urandom(32'hac21));

        repeat (8) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("exec3r_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file exec3r_tests.txt");
            other_errs++;
        end else begin
            while (!stalled && !$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") continue;
                n = $sscanf(line, "%s %d %h %h %h %h %h %h %h %h %h %h",
                            name, rnd, pa1, pd1, pa2, pd2, ins, wv, wa, wd, tr, il);
                if (n != 12) begin
                    $display("skipped a malformed line in the test file: %0s", line);
                    other_errs++;
                    continue;
                end
                // Random operands replace the file's data and its expected result
                if (rnd != 0) begin
                    pd1 = $urandom();
                    pd2 = $urandom();
                    wd  = expected_alu(ins[31:15], pd1, pd2);
                end
                exp_name     = name;
                exp_wb_valid = wv;
                exp_wb_addr  = wa;
                exp_wb_data  = wd;
                exp_trap     = tr;
                exp_illegal  = il;
                if (pa1 != 0) preload_reg(pa1, pd1);
                if (pa2 != 0) preload_reg(pa2, pd2);
                req   = 1'b1;
                instr = ins;
                tests_run++;
                wait_ack(1'b1);
                req = 1'b0;
                if (!stalled) wait_ack(1'b0);
            end
            $fclose(fd);
        end

        if (!stalled && checks_done != tests_run) begin
            $display("checker compared %0d results but %0d tests ran", checks_done, tests_run);
            other_errs++;
        end
        $display("errors: %0d value, %0d other, %0d tests", value_errs, other_errs, tests_run);
        if (value_errs == 0 && other_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* exec3r_tests.txt */
# name rnd preload1_addr preload1_data preload2_addr preload2_data instr
# then expected wb_valid wb_addr wb_data trap illegal (all hex, rnd 1 = random operands)
add_basic      0 01 00000005 02 00000007 00100823 1 03 0000000c 0 0
sub_wrap       0 01 00000003 02 00000005 00110823 1 03 fffffffe 0 0
slt_neg        0 01 ffffffff 02 00000001 00120823 1 03 00000001 0 0
sltu_neg       0 01 ffffffff 02 00000001 00128823 1 03 00000000 0 0
add_rand       1 01 00000000 02 00000000 00100823 1 03 00000000 0 0
sub_rand       1 01 00000000 02 00000000 00110823 1 03 00000000 0 0
sltu_rand      1 01 00000000 02 00000000 00128823 1 03 00000000 0 0
xor_rand       1 01 00000000 02 00000000 00158823 1 03 00000000 0 0
nor_mix        0 01 0f0f0000 02 00ff00ff 00140823 1 03 f000ff00 0 0
orn_mix        0 01 00000011 02 ffff0000 00160823 1 03 0000ffff 0 0
andn_mix       0 01 12345678 02 0000ffff 00168823 1 03 12340000 0 0
sll_big_amt    0 01 00000001 02 00000024 00170823 1 03 00000010 0 0
srl_max_amt    0 01 80000000 02 0000001f 00178823 1 03 00000001 0 0
sra_neg        0 01 80000000 02 00000004 00180823 1 03 f8000000 0 0
mul_neg        0 01 fffffffd 02 00000007 001c0823 1 03 ffffffeb 0 0
mulh_neg       0 01 80000000 02 00000002 001c8823 1 03 ffffffff 0 0
mulhu_max      0 01 ffffffff 02 ffffffff 001d0823 1 03 fffffffe 0 0
div_neg        0 01 fffffff9 02 00000002 00200823 1 03 fffffffd 0 0
mod_neg        0 01 fffffff9 02 00000002 00208823 1 03 ffffffff 0 0
divu_big       0 01 fffffff9 02 00000002 00210823 1 03 7ffffffc 0 0
modu_big       0 01 fffffff9 02 00000002 00218823 1 03 00000001 0 0
div_zero       0 01 00001234 02 00000000 00200823 1 03 00000000 0 0
modu_zero      0 01 00001234 02 00000000 00218823 1 03 00001234 0 0
div_ovf        0 01 80000000 02 ffffffff 00200823 1 03 80000000 0 0
mod_ovf        0 01 80000000 02 ffffffff 00208823 1 03 00000000 0 0
break_trap     0 00 00000000 00 00000000 002a0000 0 00 00000000 1 0
syscall_trap   0 00 00000000 00 00000000 002b0005 0 00 00000000 2 0
syscall_stop   0 00 00000000 00 00000000 002b0011 0 00 00000000 0 0
idle_trap      0 00 00000000 00 00000000 38488000 0 00 00000000 3 0
invtlb_trap    0 00 00000000 00 00000000 06498823 0 00 00000000 4 0
dbar_nop       0 00 00000000 00 00000000 38720000 0 00 00000000 0 0
ibar_nop       0 00 00000000 00 00000000 38728000 0 00 00000000 0 0
illegal_op     0 05 cafe0001 00 00000000 ffff8005 0 00 00000000 0 1
after_illegal  0 00 00000000 00 00000000 001000a6 1 06 cafe0001 0 0
r0_write       0 01 00000011 02 00000022 00100820 1 00 00000033 0 0
r0_read        0 03 00000005 00 00000000 00100c07 1 07 00000005 0 0

/* flist.f */
isa_defs_pkg.sv
core_types_pkg.sv
decoder_3r.sv
gpr_file.sv
alu_3r.sv
issue_ctrl.sv
exec3r_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_top -f flist.f -o sim_exec3r
./obj_dir/sim_exec3r | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
